//--- verilog/riscvCore_defines.svh
`ifndef RISCVCORE_DEFINES_SVH
`define RISCVCORE_DEFINES_SVH

// Datapath width
`define XLEN 32

// Register file geometry
`define REG_ADDR_W 5
`define REG_COUNT 32

// Major opcodes handled by decode
`define OPC_OP 7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI 7'b0110111

`endif

//--- verilog/riscvCorePkg.sv
`include "riscvCore_defines.svh"

package riscvCorePkg;

	// Register-register layout
	typedef struct packed {
		logic [6:0] funct7;
		logic [`REG_ADDR_W-1:0] rs2;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [2:0] funct3;
		logic [`REG_ADDR_W-1:0] rd;
		logic [6:0] opcode;
	} rTypeT;

	// Immediate layout, also covers the upper bits of LUI
	typedef struct packed {
		logic [11:0] imm12;
		logic [`REG_ADDR_W-1:0] rs1;
		logic [2:0] funct3;
		logic [`REG_ADDR_W-1:0] rd;
		logic [6:0] opcode;
	} iTypeT;

	typedef union packed {
		rTypeT rType;
		iTypeT iType;
	} instrWord;

	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR = 4'd3,
		ALU_XOR = 4'd4,
		ALU_SLT = 4'd5,
		ALU_SLL = 4'd6,
		ALU_SRL = 4'd7,
		ALU_PASSB = 4'd8
	} aluOpT;

	// rwSrc: 0 selects the ALU, 1 the immediate
	typedef struct packed {
		aluOpT aluOp;
		logic aluSrcB;
		logic rfWe;
		logic [1:0] rwSrc;
	} ctrlT;

endpackage

//--- verilog/idExBus.sv
`timescale 1ns/1ns
`include "riscvCore_defines.svh"

interface idExBus;

	logic valid;
	riscvCorePkg::ctrlT ctrl;
	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] imm;

	// Register addresses
	logic [`REG_ADDR_W-1:0] rs1;
	logic [`REG_ADDR_W-1:0] rs2;
	logic [`REG_ADDR_W-1:0] rd;

	// Operand values read in decode
	logic [`XLEN-1:0] rd1;
	logic [`XLEN-1:0] rd2;

	modport src (
		output valid,
		output ctrl,
		output pc,
		output imm,
		output rs1,
		output rs2,
		output rd,
		output rd1,
		output rd2
	);

	modport dst (
		input valid,
		input ctrl,
		input pc,
		input imm,
		input rs1,
		input rs2,
		input rd,
		input rd1,
		input rd2
	);

endinterface

//--- verilog/regFile.sv
`timescale 1ns/1ns
`include "riscvCore_defines.svh"

module regFile (
	input  logic CLK,
	input  logic RSTn,
	input  logic [`REG_ADDR_W-1:0] raddr1,
	input  logic [`REG_ADDR_W-1:0] raddr2,
	output logic [`XLEN-1:0] rdata1,
	output logic [`XLEN-1:0] rdata2,
	input  logic we,
	input  logic [`REG_ADDR_W-1:0] waddr,
	input  logic [`XLEN-1:0] wdata
);

	logic [`XLEN-1:0] regs [`REG_COUNT];
	logic wrActive;

	// Writes to x0 are dropped
	assign wrActive = we && (waddr != '0);

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wrActive) begin
			regs[waddr] <= wdata;
		end
	end

	// Same-cycle write shows through on a matching read
	always_comb begin
		if (raddr1 == '0)
			rdata1 = '0;
		else if (wrActive && (waddr == raddr1))
			rdata1 = wdata;
		else
			rdata1 = regs[raddr1];
	end

	always_comb begin
		if (raddr2 == '0)
			rdata2 = '0;
		else if (wrActive && (waddr == raddr2))
			rdata2 = wdata;
		else
			rdata2 = regs[raddr2];
	end

endmodule

//--- verilog/instrDecode.sv
`timescale 1ns/1ns
`include "riscvCore_defines.svh"

module instrDecode (
	input  logic CLK,
	input  logic RSTn,
	input  logic instrValid,
	input  riscvCorePkg::instrWord instr,
	input  logic [`XLEN-1:0] pc,
	input  logic wbWe,
	input  logic [`REG_ADDR_W-1:0] wbAddr,
	input  logic [`XLEN-1:0] wbData,
	idExBus.src bus
);

	logic [6:0] opcode;
	logic isOp;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [`REG_ADDR_W-1:0] rs1;
	logic [`REG_ADDR_W-1:0] rs2;
	logic [`REG_ADDR_W-1:0] rd;
	logic [`XLEN-1:0] imm;
	logic [`XLEN-1:0] rdata1;
	logic [`XLEN-1:0] rdata2;
	logic legal;
	riscvCorePkg::ctrlT ctrl;

	// Opcode, rd, funct3 and rs1 sit at the same place in both views
	assign opcode = instr.rType.opcode;
	assign isOp = (opcode == `OPC_OP);

	assign funct3 = instr.rType.funct3;
	assign funct7 = instr.rType.funct7;
	assign rs1 = instr.rType.rs1;
	// In I-type these bits belong to the immediate
	assign rs2 = isOp ? instr.rType.rs2 : '0;
	assign rd = instr.rType.rd;

	always_comb begin
		if (opcode == `OPC_LUI)
			imm = {instr.iType.imm12, instr.iType.rs1, instr.iType.funct3, 12'b0};
		else
			imm = {{(`XLEN-12){instr.iType.imm12[11]}}, instr.iType.imm12};
	end

	always_comb begin
		ctrl = '0;
		legal = 1'b1;
		case (opcode)
			`OPC_OP: begin
				// Only funct7 of zero, or SUB's 0100000
				if ((funct7 != 7'b0) && !((funct7 == 7'b0100000) && (funct3 == 3'b000)))
					legal = 1'b0;
				case (funct3)
					3'b000: ctrl.aluOp = funct7[5] ? riscvCorePkg::ALU_SUB : riscvCorePkg::ALU_ADD;
					3'b001: ctrl.aluOp = riscvCorePkg::ALU_SLL;
					3'b010: ctrl.aluOp = riscvCorePkg::ALU_SLT;
					3'b100: ctrl.aluOp = riscvCorePkg::ALU_XOR;
					3'b101: ctrl.aluOp = riscvCorePkg::ALU_SRL;
					3'b110: ctrl.aluOp = riscvCorePkg::ALU_OR;
					3'b111: ctrl.aluOp = riscvCorePkg::ALU_AND;
					default: legal = 1'b0;
				endcase
			end
			`OPC_OP_IMM: begin
				ctrl.aluSrcB = 1'b1;
				case (funct3)
					3'b000: ctrl.aluOp = riscvCorePkg::ALU_ADD;
					3'b010: ctrl.aluOp = riscvCorePkg::ALU_SLT;
					3'b100: ctrl.aluOp = riscvCorePkg::ALU_XOR;
					3'b110: ctrl.aluOp = riscvCorePkg::ALU_OR;
					3'b111: ctrl.aluOp = riscvCorePkg::ALU_AND;
					default: legal = 1'b0;
				endcase
			end
			`OPC_LUI: begin
				ctrl.aluOp = riscvCorePkg::ALU_PASSB;
				ctrl.aluSrcB = 1'b1;
				ctrl.rwSrc = 2'd1;
			end
			default: legal = 1'b0;
		endcase
		ctrl.rfWe = (rd != '0);
		// Unsupported encodings become bubbles
		if (!legal)
			ctrl = '0;
	end

	regFile regFile_i (
		.CLK(CLK),
		.RSTn(RSTn),
		.raddr1(rs1),
		.raddr2(rs2),
		.rdata1(rdata1),
		.rdata2(rdata2),
		.we(wbWe),
		.waddr(wbAddr),
		.wdata(wbData)
	);

	assign bus.valid = instrValid && legal;
	assign bus.ctrl = ctrl;
	assign bus.pc = pc;
	assign bus.imm = imm;
	assign bus.rs1 = rs1;
	assign bus.rs2 = rs2;
	assign bus.rd = rd;
	assign bus.rd1 = rdata1;
	assign bus.rd2 = rdata2;

endmodule

//--- verilog/pipeIdEx.sv
`timescale 1ns/1ns
`include "riscvCore_defines.svh"

module pipeIdEx (
	input logic CLK,
	input logic RSTn,
	idExBus.dst dec,
	idExBus.src exe
);

	logic valid;
	riscvCorePkg::ctrlT ctrl;
	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] imm;
	logic [`REG_ADDR_W-1:0] rs1;
	logic [`REG_ADDR_W-1:0] rs2;
	logic [`REG_ADDR_W-1:0] rd;
	logic [`XLEN-1:0] rd1;
	logic [`XLEN-1:0] rd2;

	// Bubbles advance too, valid low keeps them harmless
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			valid <= 1'b0;
			ctrl <= '0;
			pc <= '0;
			imm <= '0;
			rs1 <= '0;
			rs2 <= '0;
			rd <= '0;
			rd1 <= '0;
			rd2 <= '0;
		end else begin
			valid <= dec.valid;
			ctrl <= dec.ctrl;
			pc <= dec.pc;
			imm <= dec.imm;
			rs1 <= dec.rs1;
			rs2 <= dec.rs2;
			rd <= dec.rd;
			rd1 <= dec.rd1;
			rd2 <= dec.rd2;
		end
	end

	assign exe.valid = valid;
	assign exe.ctrl = ctrl;
	assign exe.pc = pc;
	assign exe.imm = imm;
	assign exe.rs1 = rs1;
	assign exe.rs2 = rs2;
	assign exe.rd = rd;
	assign exe.rd1 = rd1;
	assign exe.rd2 = rd2;

endmodule

//--- verilog/execStage.sv
`timescale 1ns/1ns
`include "riscvCore_defines.svh"

module execStage (
	input  logic CLK,
	input  logic RSTn,
	idExBus.dst bus,
	output logic wbWe,
	output logic [`REG_ADDR_W-1:0] wbAddr,
	output logic [`XLEN-1:0] wbData
);

	localparam int shamtW = $clog2(`XLEN);

	logic [`XLEN-1:0] opB;
	logic [shamtW-1:0] shamt;
	logic [`XLEN-1:0] aluResult;
	logic [`XLEN-1:0] result;

	// Operand B is the register or the immediate
	assign opB = bus.ctrl.aluSrcB ? bus.imm : bus.rd2;
	assign shamt = opB[shamtW-1:0];

	always_comb begin
		case (bus.ctrl.aluOp)
			riscvCorePkg::ALU_ADD: aluResult = bus.rd1 + opB;
			riscvCorePkg::ALU_SUB: aluResult = bus.rd1 - opB;
			riscvCorePkg::ALU_AND: aluResult = bus.rd1 & opB;
			riscvCorePkg::ALU_OR: aluResult = bus.rd1 | opB;
			riscvCorePkg::ALU_XOR: aluResult = bus.rd1 ^ opB;
			riscvCorePkg::ALU_SLT: begin
				aluResult = {{(`XLEN-1){1'b0}}, ($signed(bus.rd1) < $signed(opB))};
			end
			riscvCorePkg::ALU_SLL: aluResult = bus.rd1 << shamt;
			riscvCorePkg::ALU_SRL: aluResult = bus.rd1 >> shamt;
			riscvCorePkg::ALU_PASSB: aluResult = opB;
			default: aluResult = '0;
		endcase
	end

	// Write-back source
	always_comb begin
		case (bus.ctrl.rwSrc)
			2'd1: result = bus.imm;
			default: result = aluResult;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			wbWe <= 1'b0;
			wbAddr <= '0;
			wbData <= '0;
		end else begin
			wbWe <= bus.valid && bus.ctrl.rfWe;
			wbAddr <= bus.rd;
			wbData <= result;
		end
	end

endmodule

//--- verilog/riscvCore.sv
`timescale 1ns/1ns
`include "riscvCore_defines.svh"

module riscvCore (
	input  logic CLK,
	input  logic RSTn,
	input  logic instrValid,
	input  logic [`XLEN-1:0] instr,
	input  logic [`XLEN-1:0] pc,
	output logic wbValid,
	output logic [`REG_ADDR_W-1:0] wbAddr,
	output logic [`XLEN-1:0] wbData
);

	idExBus decBus ();
	idExBus exeBus ();

	instrDecode instrDecode_i (
		.CLK(CLK),
		.RSTn(RSTn),
		.instrValid(instrValid),
		.instr(instr),
		.pc(pc),
		.wbWe(wbValid),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.bus(decBus.src)
	);

	pipeIdEx pipeIdEx_i (
		.CLK(CLK),
		.RSTn(RSTn),
		.dec(decBus.dst),
		.exe(exeBus.src)
	);

	// Write-back also loops back into decode's register file
	execStage execStage_i (
		.CLK(CLK),
		.RSTn(RSTn),
		.bus(exeBus.dst),
		.wbWe(wbValid),
		.wbAddr(wbAddr),
		.wbData(wbData)
	);

endmodule

//--- testbench/riscvCore_checker.sv
`timescale 1ns/1ns
`include "riscvCore_defines.svh"

module riscvCore_checker (
	input logic CLK,
	input logic RSTn,
	input logic instrValid,
	input logic [`XLEN-1:0] instr,
	input logic wbValid,
	input logic [`REG_ADDR_W-1:0] wbAddr
);

	int failCount = 0;
	logic knownOpcode;
	logic writes;

	// Whether a result comes back depends only on opcode and rd
	assign knownOpcode = (instr[6:0] == `OPC_OP) || (instr[6:0] == `OPC_OP_IMM)
		|| (instr[6:0] == `OPC_LUI);
	assign writes = instrValid && knownOpcode && (instr[11:7] != '0);

	resetQuiet: assert property (@(posedge CLK) RSTn |=> !wbValid ##1 !wbValid)
	else begin
		failCount++;
		$error("wbValid active during reset or in the cycle after it");
	end

	noZeroWrite: assert property (@(posedge CLK) disable iff (RSTn) wbValid |-> wbAddr != '0)
	else begin
		failCount++;
		$error("wbValid high with wbAddr of x0");
	end

	// Two edges from sampling to write-back, with the same rd
	writeLatency: assert property (@(posedge CLK) disable iff (RSTn)
		writes |-> ##2 (wbValid && wbAddr == $past(instr[11:7], 2)))
	else begin
		failCount++;
		$error("writing instruction did not reach write-back two edges later");
	end

	noSpuriousWrite: assert property (@(posedge CLK) disable iff (RSTn)
		wbValid |-> $past(writes, 2))
	else begin
		failCount++;
		$error("wbValid without a writing instruction two edges before");
	end

endmodule

//--- testbench/riscvCore_tb.sv
`timescale 1ns/1ns
`include "riscvCore_defines.svh"

module riscvCore_tb;

	typedef enum int {
		opAdd, opSub, opAnd, opOr, opXor, opSlt, opSll, opSrl,
		opAddi, opAndi, opOri, opXori, opSlti, opLui
	} opKindT;

	logic CLK;
	logic RSTn;
	logic instrValid;
	logic [`XLEN-1:0] instr;
	logic [`XLEN-1:0] pc;
	logic wbValid;
	logic [`REG_ADDR_W-1:0] wbAddr;
	logic [`XLEN-1:0] wbData;

	logic [31:0] lfsr;
	logic [`XLEN-1:0] shadow [`REG_COUNT];
	logic [`REG_ADDR_W-1:0] expRd [$];
	logic [`XLEN-1:0] expData [$];
	logic [`REG_ADDR_W-1:0] headRd;
	logic [`XLEN-1:0] headData;
	int errorCount;
	int checkCount;
	int testCount;
	int testFails;
	int testStartErrors;

	riscvCore riscvCore_i (
		.CLK(CLK),
		.RSTn(RSTn),
		.instrValid(instrValid),
		.instr(instr),
		.pc(pc),
		.wbValid(wbValid),
		.wbAddr(wbAddr),
		.wbData(wbData)
	);

	bind riscvCore riscvCore_checker riscvCore_checker_i (
		.CLK(CLK),
		.RSTn(RSTn),
		.instrValid(instrValid),
		.instr(instr),
		.wbValid(wbValid),
		.wbAddr(wbAddr)
	);

	always #5 CLK = ~CLK;

	// Outputs are read before this edge updates them
	always @(posedge CLK) begin
		if (!RSTn && wbValid) begin
			if (expRd.size() == 0) begin
				errorCount++;
				$display("Write-back to x%0d arrived with nothing outstanding", wbAddr);
			end else begin
				headRd = expRd.pop_front();
				headData = expData.pop_front();
				checkCount++;
				assert (wbAddr == headRd)
				else begin
					errorCount++;
					$display("FAILED wbAddr: expected %h, got %h", headRd, wbAddr);
				end
				assert (wbData == headData)
				else begin
					errorCount++;
					$display("FAILED wbData: expected %h, got %h", headData, wbData);
				end
			end
		end
	end

	// Galois LFSR, one step per bit
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic [31:0] buildOp(input opKindT kind, input logic [4:0] rd,
			input logic [4:0] rs1, input logic [4:0] rs2, input logic [19:0] imm);
		case (kind)
			opAdd: return {7'b0000000, rs2, rs1, 3'b000, rd, `OPC_OP};
			opSub: return {7'b0100000, rs2, rs1, 3'b000, rd, `OPC_OP};
			opAnd: return {7'b0000000, rs2, rs1, 3'b111, rd, `OPC_OP};
			opOr: return {7'b0000000, rs2, rs1, 3'b110, rd, `OPC_OP};
			opXor: return {7'b0000000, rs2, rs1, 3'b100, rd, `OPC_OP};
			opSlt: return {7'b0000000, rs2, rs1, 3'b010, rd, `OPC_OP};
			opSll: return {7'b0000000, rs2, rs1, 3'b001, rd, `OPC_OP};
			opSrl: return {7'b0000000, rs2, rs1, 3'b101, rd, `OPC_OP};
			opAddi: return {imm[11:0], rs1, 3'b000, rd, `OPC_OP_IMM};
			opAndi: return {imm[11:0], rs1, 3'b111, rd, `OPC_OP_IMM};
			opOri: return {imm[11:0], rs1, 3'b110, rd, `OPC_OP_IMM};
			opXori: return {imm[11:0], rs1, 3'b100, rd, `OPC_OP_IMM};
			opSlti: return {imm[11:0], rs1, 3'b010, rd, `OPC_OP_IMM};
			default: return {imm, rd, `OPC_LUI};
		endcase
	endfunction

	function automatic int totalErrors();
		return errorCount + riscvCore_i.riscvCore_checker_i.failCount;
	endfunction

	// Expected result follows the ISA, from the shadow registers
	task automatic issue(input opKindT kind, input logic [4:0] rd, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic [19:0] imm);
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		w = buildOp(kind, rd, rs1, rs2, imm);
		a = shadow[w[19:15]];
		b = (w[6:0] == `OPC_OP) ? shadow[w[24:20]] : {{20{w[31]}}, w[31:20]};
		case (w[14:12])
			3'b000: res = ((w[6:0] == `OPC_OP) && w[30]) ? a - b : a + b;
			3'b001: res = a << b[4:0];
			3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b100: res = a ^ b;
			3'b101: res = a >> b[4:0];
			3'b110: res = a | b;
			default: res = a & b;
		endcase
		if (w[6:0] == `OPC_LUI)
			res = {w[31:12], 12'b0};
		if (w[11:7] != 5'd0) begin
			shadow[w[11:7]] = res;
			expRd.push_back(w[11:7]);
			expData.push_back(res);
		end
		@(posedge CLK);
		instrValid <= 1'b1;
		instr <= w;
		pc <= pc + 32'd4;
	endtask

	task automatic bubble(input int n);
		repeat (n) begin
			@(posedge CLK);
			instrValid <= 1'b0;
		end
	endtask

	task automatic endTest(input string name);
		int waited;
		int errs;
		bubble(1);
		waited = 0;
		while (expRd.size() != 0 && waited < 20) begin
			@(posedge CLK);
			waited++;
		end
		if (expRd.size() != 0) begin
			errorCount++;
			$display("Timeout: %0d write-backs never arrived in %s", expRd.size(), name);
			expRd.delete();
			expData.delete();
		end
		errs = totalErrors() - testStartErrors;
		testCount++;
		if (errs != 0)
			testFails++;
		$display("Test %0d %s: %0d errors", testCount, name, errs);
		testStartErrors = totalErrors();
	endtask

	// Producer must sit two or more cycles ahead of its reader
	task automatic randomMix(input int count);
		opKindT kind;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] prevRd;
		logic readsPrev;
		int gap;
		prevRd = '0;
		gap = 1;
		for (int n = 0; n < count; n++) begin
			kind = opKindT'(randBits(4) % 14);
			rd = 5'(randBits(5));
			rs1 = 5'(randBits(5));
			rs2 = 5'(randBits(5));
			readsPrev = (kind != opLui) && ((rs1 == prevRd) || ((kind <= opSrl) && (rs2 == prevRd)));
			if (gap == 0 && prevRd != 5'd0 && readsPrev)
				bubble(1);
			issue(kind, rd, rs1, rs2, 20'(randBits(20)));
			prevRd = rd;
			gap = int'(randBits(2));
			bubble(gap);
		end
	endtask

	initial begin
		CLK = 1'b0;
		RSTn = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		pc = '0;
		lfsr = 32'd74490;
		errorCount = 0;
		checkCount = 0;
		testCount = 0;
		testFails = 0;
		testStartErrors = 0;
		for (int i = 0; i < `REG_COUNT; i++)
			shadow[i] = '0;

		// Five reset edges, then two quiet cycles
		for (int i = 0; i < 7; i++) begin
			@(posedge CLK);
			if (i == 4)
				RSTn <= 1'b0;
			if (i > 0) begin
				assert (wbValid === 1'b0)
				else begin
					errorCount++;
					$display("FAILED wbValid: expected %h, got %h", 1'b0, wbValid);
				end
			end
		end
		endTest("reset");

		issue(opAddi, 1, 0, 0, 12'h7FF);
		issue(opAddi, 2, 0, 0, 12'hFFD);
		issue(opAddi, 3, 0, 0, 12'h001);
		bubble(1);
		issue(opAdd, 4, 1, 2, 0);
		issue(opSub, 5, 0, 3, 0);
		issue(opSub, 6, 2, 1, 0);
		issue(opAnd, 7, 1, 2, 0);
		issue(opOr, 8, 1, 2, 0);
		issue(opXor, 9, 1, 2, 0);
		issue(opSlt, 10, 2, 1, 0);
		issue(opSlt, 11, 1, 2, 0);
		issue(opSll, 12, 1, 2, 0);
		issue(opSll, 13, 3, 1, 0);
		issue(opSrl, 14, 2, 3, 0);
		issue(opSrl, 15, 1, 3, 0);
		endTest("R-type ALU");

		issue(opAddi, 16, 1, 0, 12'hF9C);
		issue(opAndi, 17, 2, 0, 12'hFF0);
		issue(opOri, 18, 3, 0, 12'hF00);
		issue(opXori, 19, 1, 0, 12'hFFF);
		issue(opSlti, 20, 2, 0, 12'hFFE);
		issue(opSlti, 21, 3, 0, 12'hFFF);
		issue(opLui, 22, 0, 0, 20'hABCDE);
		issue(opLui, 23, 0, 0, 20'h80000);
		endTest("I-type and LUI");

		issue(opAddi, 0, 1, 0, 12'h005);
		issue(opAdd, 0, 1, 2, 0);
		issue(opLui, 0, 0, 0, 20'h12345);
		bubble(1);
		issue(opAdd, 24, 0, 1, 0);
		issue(opOri, 25, 0, 0, 12'h000);
		endTest("x0 writes");

		issue(opAddi, 26, 0, 0, 12'h064);
		issue(opAddi, 27, 0, 0, 12'hFF9);
		issue(opXori, 28, 3, 0, 12'h055);
		issue(opLui, 29, 0, 0, 20'h00F0F);
		issue(opOri, 30, 1, 0, 12'h100);
		issue(opAndi, 31, 2, 0, 12'h0FF);
		bubble(1);
		issue(opAdd, 26, 31, 27, 0);
		bubble(1);
		issue(opSub, 27, 26, 31, 0);
		endTest("back-to-back and dependent");

		randomMix(200);
		endTest("random mix");

		$display("Tests %0d, failed %0d, write-backs checked %0d, errors %0d",
			testCount, testFails, checkCount, totalErrors());
		if (totalErrors() == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- riscvCore.f
+incdir+verilog
verilog/riscvCorePkg.sv
verilog/idExBus.sv
verilog/regFile.sv
verilog/instrDecode.sv
verilog/pipeIdEx.sv
verilog/execStage.sv
verilog/riscvCore.sv
testbench/riscvCore_checker.sv
testbench/riscvCore_tb.sv

//--- Bender.yml
package:
  name: riscv_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/riscvCorePkg.sv
      - verilog/idExBus.sv
      - verilog/regFile.sv
      - verilog/instrDecode.sv
      - verilog/pipeIdEx.sv
      - verilog/execStage.sv
      - verilog/riscvCore.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - testbench/riscvCore_checker.sv
      - testbench/riscvCore_tb.sv
